//--- vic_loader.f
hdl/vic_loader_pkg.sv
hdl/load_header_parser.sv
hdl/cart_block_tracker.sv
hdl/ptr_slot_counter.sv
hdl/basic_ptr_sequencer.sv
hdl/mem_write_port.sv
hdl/vic_loader_top.sv
testbench/tb_vic_loader.sv

//--- testbench/tb_vic_loader.sv
`timescale 1ns/1ns

module tb_vic_loader
	import vic_loader_pkg::*;
();

	// One download per row, with what the loader must do with it
	typedef struct packed {
		logic [7:0]  index;
		logic [7:0]  ext_char;
		logic        has_hdr;
		logic [15:0] hdr_addr;
		logic [24:0] start_off;
		logic [24:0] count;
		logic [15:0] exp_first;
		logic [24:0] exp_writes;
		logic        chk_end;
		logic [15:0] exp_end;
		logic [4:0]  exp_blk;
		logic        detach;
	} row_t;

	localparam int ROWS = 5;

	logic         clk_sys = 1'b0;
	logic         reset;
	load_stream_t stream;
	logic         detach;
	mem_write_t   mem_wr;
	cart_blk_t    cart_blk;
	logic         cart_reset;

	row_t        rows [0:ROWS-1];
	byte_t       patch_addr [0:7];
	logic [31:0] lfsr;
	int          checks;
	int          errors;
	int          r;

	vic_loader_top dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.stream     (stream),
		.detach     (detach),
		.mem_wr     (mem_wr),
		.cart_blk   (cart_blk),
		.cart_reset (cart_reset)
	);

	always #10 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Checking and stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_byte(output byte_t b);
		int k;
		b = '0;
		for (k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// Load address of a raw cartridge from its extension character
	function automatic vic_addr_t ct_base(input byte_t c);
		vic_addr_t base;
		base = '0;
		if ((c >= 8'h32) && (c <= 8'h39))
			base = 16'h1000 * (c - 8'h30);
		else if (c == 8'h41)
			base = 16'hA000;
		else if (c == 8'h42)
			base = 16'hB000;
		return base;
	endfunction

	function automatic row_t make_row(
		input logic [7:0] index, input logic [7:0] ext_char,
		input logic has_hdr, input logic [15:0] hdr_addr,
		input logic [24:0] start_off, input logic [24:0] count,
		input logic [15:0] exp_first, input logic [24:0] exp_writes,
		input logic chk_end, input logic [15:0] exp_end,
		input logic [4:0] exp_blk, input logic detach
	);
		row_t row;
		row.index      = index;
		row.ext_char   = ext_char;
		row.has_hdr    = has_hdr;
		row.hdr_addr   = hdr_addr;
		row.start_off  = start_off;
		row.count      = count;
		row.exp_first  = exp_first;
		row.exp_writes = exp_writes;
		row.chk_end    = chk_end;
		row.exp_end    = exp_end;
		row.exp_blk    = exp_blk;
		row.detach     = detach;
		return row;
	endfunction

	task automatic build_table();
		rows[0] = make_row(IDX_PRG, 8'h00, 1'b1, 16'h1001, 25'd2, 25'd20,
			16'h1001, 25'd20, 1'b1, 16'h1015, 5'b00000, 1'b0);
		rows[1] = make_row(IDX_PRG, 8'h00, 1'b1, 16'h9FFE, 25'd2, 25'd4,
			16'h9FFE, 25'd2, 1'b1, 16'hA000, 5'b00000, 1'b0);
		rows[2] = make_row(IDX_ROM, 8'h00, 1'b0, 16'h0000, 25'd0, 25'h9000,
			16'hC000, 25'h4000, 1'b0, 16'h0000, 5'b00000, 1'b0);
		rows[3] = make_row(IDX_CRT, 8'h00, 1'b1, 16'h2000, 25'd2, 25'h2001,
			16'h2000, 25'h2001, 1'b1, 16'h4001, 5'b00110, 1'b0);
		rows[4] = make_row(IDX_CT, 8'h41, 1'b0, 16'h0000, 25'd0, 25'd16,
			16'hA000, 25'd16, 1'b1, 16'hA010, 5'b10110, 1'b1);
		// BASIC pointer bytes, low and high end byte in turn
		patch_addr = '{8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31, 8'h32, 8'hAE, 8'hAF};
	endtask

	// Called on a falling edge, returns on the falling edge two cycles later
	task automatic send_byte(input stream_addr_t off, input byte_t d, output mem_write_t seen);
		stream.addr = off;
		stream.data = d;
		stream.wr   = 1'b1;
		@(negedge clk_sys);
		seen = mem_wr;
		stream.wr = 1'b0;
		@(negedge clk_sys);
		compare("mem_wr.wr idle", mem_wr.wr, 1'b0);
	endtask

	task automatic wait_write(input int limit, output bit found, output int cycles);
		int n;
		found  = 1'b0;
		cycles = 0;
		for (n = 0; (n < limit) && !found; n++) begin
			@(negedge clk_sys);
			cycles = n + 1;
			if (mem_wr.wr)
				found = 1'b1;
		end
	endtask

	task automatic check_patch(input vic_addr_t end_addr);
		bit found;
		int cycles;
		int k;
		wait_write(40, found, cycles);
		if (!found) begin
			errors++;
			$display("Timeout at %0t: no pointer patch write after the program download", $time);
		end else begin
			// Drop of download, prg_done, then the first write
			compare("patch latency", cycles, 3);
			for (k = 0; k < 8; k++) begin
				compare("patch mem_wr.wr", mem_wr.wr, 1'b1);
				compare("patch mem_wr.addr", mem_wr.addr, {8'h00, patch_addr[k]});
				compare("patch mem_wr.data", mem_wr.data, k[0] ? end_addr[15:8] : end_addr[7:0]);
				@(negedge clk_sys);
				compare("patch gap mem_wr.wr", mem_wr.wr, 1'b0);
				@(negedge clk_sys);
			end
			compare("patch end mem_wr.wr", mem_wr.wr, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One table row, with a reference model of the address rules
	//////////////////////////////////////////////////////////////////////

	task automatic run_row(input row_t row);
		vic_addr_t    model_addr;
		vic_addr_t    limit;
		vic_addr_t    exp_addr;
		vic_addr_t    first;
		vic_addr_t    last_wr;
		vic_addr_t    end_seen;
		stream_addr_t off;
		mem_write_t   seen;
		byte_t        d;
		logic         exp_wr;
		logic         is_rom;
		int           n_wr;
		int           i;

		is_rom     = (row.index == IDX_ROM);
		limit      = (row.index == IDX_PRG) ? 16'hA000 : 16'hC000;
		model_addr = row.has_hdr ? row.hdr_addr : ct_base(row.ext_char);
		first      = '0;
		last_wr    = '0;
		n_wr       = 0;

		stream.index    = row.index;
		stream.ext_char = row.ext_char;
		stream.download = 1'b1;
		@(negedge clk_sys);

		if (row.has_hdr) begin
			send_byte(25'd0, row.hdr_addr[7:0], seen);
			compare("header lo mem_wr.wr", seen.wr, 1'b0);
			send_byte(25'd1, row.hdr_addr[15:8], seen);
			compare("header hi mem_wr.wr", seen.wr, 1'b0);
		end

		for (i = 0; i < int'(row.count); i++) begin
			off = row.start_off + stream_addr_t'(i);
			take_byte(d);
			if (is_rom) begin
				exp_wr   = (off >= 25'h4000) && (off < 25'h8000);
				exp_addr = off[15:0] + 16'h8000;
			end else begin
				exp_wr   = (model_addr < limit);
				exp_addr = model_addr;
			end
			send_byte(off, d, seen);
			compare("mem_wr.wr", seen.wr, exp_wr);
			if (exp_wr && seen.wr) begin
				compare("mem_wr.addr", seen.addr, exp_addr);
				compare("mem_wr.data", seen.data, d);
			end
			if (seen.wr) begin
				if (n_wr == 0)
					first = seen.addr;
				last_wr = seen.addr;
				n_wr++;
			end
			if (!is_rom && exp_wr)
				model_addr++;
			compare("cart_reset", cart_reset, row.index == IDX_CRT);
		end

		stream.download = 1'b0;
		if (row.index == IDX_PRG)
			check_patch(row.exp_end);
		else
			repeat (2) @(negedge clk_sys);

		compare("write count", n_wr, row.exp_writes);
		compare("first write addr", first, row.exp_first);
		if (row.chk_end) begin
			// End address is one past the last byte the loader wrote
			end_seen = last_wr + 16'd1;
			compare("end addr", end_seen, row.exp_end);
		end
		compare("cart_reset after", cart_reset, 1'b0);
		compare("cart_blk", cart_blk, row.exp_blk);

		if (row.detach) begin
			// Open a CRT download so that cart_reset is high when detach lands
			stream.index    = IDX_CRT;
			stream.download = 1'b1;
			@(negedge clk_sys);
			compare("cart_reset before detach", cart_reset, 1'b1);
			detach = 1'b1;
			@(negedge clk_sys);
			detach          = 1'b0;
			stream.download = 1'b0;
			compare("cart_blk detach", cart_blk, 5'b00000);
			compare("cart_reset detach", cart_reset, 1'b0);
		end
	endtask

	initial begin
		stream = '0;
		detach = 1'b0;
		reset  = 1'b1;
		lfsr   = 32'h3630;
		checks = 0;
		errors = 0;
		build_table();

		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		compare("mem_wr.wr reset", mem_wr.wr, 1'b0);
		compare("cart_blk reset", cart_blk, 5'b00000);
		compare("cart_reset reset", cart_reset, 1'b0);

		for (r = 0; r < ROWS; r++) begin
			$display("Row %0d: index %h, %0d bytes", r, rows[r].index, rows[r].count);
			run_row(rows[r]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- hdl/vic_loader_top.sv
`timescale 1ns/1ns

module vic_loader_top
	import vic_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  load_stream_t stream,
	input  logic         detach,
	output mem_write_t   mem_wr,
	output cart_blk_t    cart_blk,
	output logic         cart_reset
);

	load_kind_e load_kind;
	vic_addr_t  run_addr;
	logic       byte_take;
	logic       prg_done;
	mem_write_t ptr_wr;

	load_header_parser u_parser (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.stream    (stream),
		.load_kind (load_kind),
		.run_addr  (run_addr),
		.byte_take (byte_take),
		.prg_done  (prg_done)
	);

	mem_write_port u_wr_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.stream    (stream),
		.load_kind (load_kind),
		.run_addr  (run_addr),
		.byte_take (byte_take),
		.ptr_wr    (ptr_wr),
		.mem_wr    (mem_wr)
	);

	cart_block_tracker u_cart (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_kind  (load_kind),
		.download   (stream.download),
		.byte_take  (byte_take),
		.run_addr   (run_addr),
		.detach     (detach),
		.cart_blk   (cart_blk),
		.cart_reset (cart_reset)
	);

	// run_addr holds the end address by the time prg_done fires
	basic_ptr_sequencer u_ptr_seq (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.prg_done  (prg_done),
		.end_addr  (run_addr),
		.load_kind (load_kind),
		.download  (stream.download),
		.ptr_wr    (ptr_wr)
	);

endmodule

//--- hdl/mem_write_port.sv
`timescale 1ns/1ns

module mem_write_port
	import vic_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  load_stream_t stream,
	input  load_kind_e   load_kind,
	input  vic_addr_t    run_addr,
	input  logic         byte_take,
	input  mem_write_t   ptr_wr,
	output mem_write_t   mem_wr
);

	logic       rom_hit;
	logic       stream_hit;
	mem_write_t next_wr;

	// Kernal bytes only inside the 16K window of the file
	assign rom_hit = (load_kind == LOAD_ROM) && stream.download && stream.wr &&
		(stream.addr >= ROM_WIN_LO) && (stream.addr < ROM_WIN_HI);

	assign stream_hit = rom_hit || byte_take;

	//////////////////////////////////////////////////////////////////////
	// Write select, patch sequencer first
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_wr = ptr_wr;
		if (!ptr_wr.wr) begin
			if (rom_hit) begin
				next_wr.wr   = 1'b1;
				next_wr.addr = vic_addr_t'(stream.addr[15:0] + ROM_OFFSET);
				next_wr.data = stream.data;
			end else if (byte_take) begin
				next_wr.wr   = 1'b1;
				next_wr.addr = run_addr;
				next_wr.data = stream.data;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			mem_wr <= '0;
		else
			mem_wr <= next_wr;
	end

	// Patches run only between downloads, so the two sources never meet
	a_no_collision: assert property (@(posedge clk_sys) disable iff (reset)
		!(ptr_wr.wr && stream_hit))
		else $error("pointer patch and stream byte in the same cycle");

endmodule

//--- hdl/basic_ptr_sequencer.sv
`timescale 1ns/1ns

module basic_ptr_sequencer
	import vic_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       prg_done,
	input  vic_addr_t  end_addr,
	input  load_kind_e load_kind,
	input  logic       download,
	output mem_write_t ptr_wr
);

	seq_state_e state;
	seq_state_e state_next;
	vic_addr_t  end_q;
	ptr_slot_t  slot;
	logic       last;
	logic       abort;
	logic       slot_clear;
	logic       slot_advance;

	// A fresh PRG or kernal download overrides any pending patch
	assign abort = download && ((load_kind == LOAD_PRG) || (load_kind == LOAD_ROM));

	assign slot_clear   = prg_done || abort;
	assign slot_advance = (state == SEQ_WRITE);

	ptr_slot_counter u_slot_cnt (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (slot_clear),
		.advance (slot_advance),
		.slot    (slot),
		.last    (last)
	);

	//////////////////////////////////////////////////////////////////////
	// Write, gap, write ... one pointer byte every other cycle
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			SEQ_IDLE:  if (prg_done) state_next = SEQ_WRITE;
			SEQ_WRITE: state_next = last ? SEQ_IDLE : SEQ_GAP;
			SEQ_GAP:   state_next = SEQ_WRITE;
			default:   state_next = SEQ_IDLE;
		endcase
		if (abort)
			state_next = SEQ_IDLE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			state <= SEQ_IDLE;
		else
			state <= state_next;
	end

	// End address is sampled once, as the patch starts
	always_ff @(posedge clk_sys) begin
		if (reset)
			end_q <= '0;
		else if (prg_done)
			end_q <= end_addr;
	end

	// Even slots take the low byte, odd slots the high byte
	assign ptr_wr.wr   = (state == SEQ_WRITE) && !abort;
	assign ptr_wr.addr = {8'h00, PTR_ADDR_TABLE[slot]};
	assign ptr_wr.data = slot[0] ? end_q[15:8] : end_q[7:0];

	a_single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		ptr_wr.wr |=> !ptr_wr.wr)
		else $error("pointer write held for two cycles");

endmodule

//--- hdl/ptr_slot_counter.sv
`timescale 1ns/1ns

module ptr_slot_counter
	import vic_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      clear,
	input  logic      advance,
	output ptr_slot_t slot,
	output logic      last
);

	assign last = (slot == ptr_slot_t'(PTR_SLOTS - 1));

	always_ff @(posedge clk_sys) begin
		if (reset || clear) begin
			slot <= '0;
		end else if (advance) begin
			// Wrap back to slot 0 after the final pointer byte
			if (last)
				slot <= '0;
			else
				slot <= slot + ptr_slot_t'(1);
		end
	end

endmodule

//--- hdl/cart_block_tracker.sv
`timescale 1ns/1ns

module cart_block_tracker
	import vic_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  load_kind_e load_kind,
	input  logic       download,
	input  logic       byte_take,
	input  vic_addr_t  run_addr,
	input  logic       detach,
	output cart_blk_t  cart_blk,
	output logic       cart_reset
);

	logic      cart_kind;
	cart_blk_t blk_hit;

	assign cart_kind = (load_kind == LOAD_CRT) || (load_kind == LOAD_CT);

	// 8K block of the byte being written, from the top three address bits
	always_comb begin
		blk_hit = '0;
		case (run_addr[15:13])
			3'd0: blk_hit[0] = 1'b1;
			3'd1: blk_hit[1] = 1'b1;
			3'd2: blk_hit[2] = 1'b1;
			3'd3: blk_hit[3] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: blk_hit = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset || detach) begin
			cart_blk   <= '0;
			cart_reset <= 1'b0;
		end else begin
			// Machine stays in reset while a CRT image streams in
			cart_reset <= download && (load_kind == LOAD_CRT);

			if (byte_take && cart_kind)
				cart_blk <= cart_blk | blk_hit;
		end
	end

endmodule

//--- hdl/load_header_parser.sv
`timescale 1ns/1ns

module load_header_parser
	import vic_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  load_stream_t stream,
	output load_kind_e   load_kind,
	output vic_addr_t    run_addr,
	output logic         byte_take,
	output logic         prg_done
);

	logic      download_q;
	logic      start_edge;
	logic      end_edge;
	logic      strobe;
	logic      has_header;
	logic      data_kind;
	logic      hdr_lo;
	logic      hdr_hi;
	logic      ct_digit;
	logic      ct_letter;
	vic_addr_t limit;

	// Index decode, held after the download ends
	always_comb begin
		load_kind = LOAD_NONE;
		case (stream.index)
			IDX_PRG: load_kind = LOAD_PRG;
			IDX_CRT: load_kind = LOAD_CRT;
			IDX_CT:  load_kind = LOAD_CT;
			IDX_ROM: load_kind = LOAD_ROM;
			default: load_kind = LOAD_NONE;
		endcase
	end

	assign start_edge = stream.download & ~download_q;
	assign end_edge   = ~stream.download & download_q;
	assign strobe     = stream.download & stream.wr;

	// PRG and CRT carry a two byte load address in front
	assign has_header = (load_kind == LOAD_PRG) || (load_kind == LOAD_CRT);
	assign data_kind  = has_header || (load_kind == LOAD_CT);
	assign hdr_lo     = has_header && (stream.addr == stream_addr_t'(0));
	assign hdr_hi     = has_header && (stream.addr == stream_addr_t'(1));

	assign limit = (load_kind == LOAD_PRG) ? PRG_LIMIT : CART_LIMIT;

	assign byte_take = strobe && data_kind && !hdr_lo && !hdr_hi && (run_addr < limit);

	// Raw cartridges: "2".."9" or "A"/"B" in the extension picks the 4K page
	assign ct_digit  = (stream.ext_char >= "2") && (stream.ext_char <= "9");
	assign ct_letter = (stream.ext_char >= "A") && (stream.ext_char <= "B");

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			prg_done   <= 1'b0;
		end else begin
			download_q <= stream.download;
			prg_done   <= end_edge && (load_kind == LOAD_PRG);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			run_addr <= '0;
		end else if (start_edge && (load_kind == LOAD_CT)) begin
			if (ct_digit)
				run_addr <= {stream.ext_char[3:0], 12'h000};
			else if (ct_letter)
				run_addr <= {4'(stream.ext_char[3:0] + 4'd9), 12'h000};
		end else if (strobe && hdr_lo) begin
			run_addr[7:0] <= stream.data;
		end else if (strobe && hdr_hi) begin
			run_addr[15:8] <= stream.data;
		end else if (byte_take) begin
			run_addr <= run_addr + 16'd1;
		end
	end

	// The pointer patch must only start once the host has let go
	a_done_outside_dl: assert property (@(posedge clk_sys) disable iff (reset)
		prg_done |-> !stream.download)
		else $error("prg_done raised during a download");

endmodule

//--- hdl/vic_loader_pkg.sv
package vic_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and plain vector types
	//////////////////////////////////////////////////////////////////////

	localparam int VIC_AW    = 16;
	localparam int STREAM_AW = 25;

	typedef logic [7:0]           byte_t;
	typedef logic [VIC_AW-1:0]    vic_addr_t;
	typedef logic [STREAM_AW-1:0] stream_addr_t;

	// One flag per block: $0000, $2000, $4000, $6000, $A000
	typedef logic [4:0] cart_blk_t;
	typedef logic [2:0] ptr_slot_t;

	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_CT,
		LOAD_ROM
	} load_kind_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_GAP,
		SEQ_WRITE
	} seq_state_e;

	// Host download stream, one byte per wr strobe
	typedef struct packed {
		logic         download;
		logic [7:0]   index;
		logic         wr;
		stream_addr_t addr;
		byte_t        data;
		logic [7:0]   ext_char;
	} load_stream_t;

	typedef struct packed {
		logic      wr;
		vic_addr_t addr;
		byte_t     data;
	} mem_write_t;

	//////////////////////////////////////////////////////////////////////
	// Host index codes, limits and the pointer table
	//////////////////////////////////////////////////////////////////////

	localparam byte_t IDX_PRG = 8'h01;
	localparam byte_t IDX_CRT = 8'h41;
	localparam byte_t IDX_CT  = 8'h81;
	localparam byte_t IDX_ROM = 8'h06;

	// Exclusive upper bounds
	localparam vic_addr_t PRG_LIMIT  = 16'hA000;
	localparam vic_addr_t CART_LIMIT = 16'hC000;

	// Kernal image sits in the middle 16K of the file
	localparam stream_addr_t ROM_WIN_LO = 25'h000_4000;
	localparam stream_addr_t ROM_WIN_HI = 25'h000_8000;
	localparam vic_addr_t    ROM_OFFSET = 16'h8000;

	localparam int PTR_SLOTS = 8;

	// BASIC start-of-variables, arrays, strings and end of program
	localparam byte_t PTR_ADDR_TABLE [0:PTR_SLOTS-1] = '{
		8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31, 8'h32, 8'hAE, 8'hAF
	};

endpackage
